/* vlog.f */
+incdir+src
src/ppu_pkg.sv
src/ppu_raster_ctrl.sv
src/ppu_blender.sv
src/ppu_palette_mapper.sv
src/ppu_backend.sv
sim/ppu_backend_chk.sv
sim/tb_ppu_backend.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ppu_backend
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

.PHONY: sim clean

/* sim/tb_ppu_backend.sv */
`include "ppu_settings.svh"

module tb_ppu_backend;

	localparam int N_TESTS = 12;
	localparam int N_PAL   = 4;
	localparam int DISP_W  = 5;
	localparam int DISP_H  = 2;
	localparam int LIMIT   = N_TESTS * 20 + 200;

	logic                                       clk_ppu;
	logic                                       rst_n_ppu;
	ppu_pkg::ppu_cfg_t                          cfg;
	logic                                       run;
	logic                                       halt;
	logic [`PPU_N_LAYERS-1:0]                   layer_vld;
	ppu_pkg::ppu_layer_px_t [`PPU_N_LAYERS-1:0] layer_px;
	logic                                       layer_rdy;
	ppu_pkg::ppu_pram_wr_t                      pram_wr;
	logic                                       pix_vld;
	ppu_pkg::ppu_rgb_t                          pix;
	logic                                       pix_rdy;
	ppu_pkg::ppu_beam_t                         beam;
	logic                                       running;

	// Test table, one entry per blended pixel
	logic [`PPU_N_LAYERS-1:0]  t_opq  [N_TESTS];
	logic [`PPU_N_LAYERS-1:0]  t_pal  [N_TESTS];
	logic [`PPU_W_PIXDATA-1:0] t_word [N_TESTS][`PPU_N_LAYERS];
	logic [`PPU_W_PIXDATA-1:0] t_exp  [N_TESTS];
	logic [`PPU_W_PAL_IDX-1:0] p_addr [N_PAL];
	logic [`PPU_W_PIXDATA-1:0] p_data [N_PAL];

	// Scoreboard
	int                        sb_id  [$];
	logic [`PPU_W_PIXDATA-1:0] sb_exp [$];

	int seed;
	int n_pass;
	int n_fail;
	int n_acc;
	int n_out;
	int cycles;

	ppu_backend uut (
		.clk_ppu     (clk_ppu),
		.rst_n_ppu   (rst_n_ppu),
		.cfg_i       (cfg),
		.run_i       (run),
		.halt_i      (halt),
		.layer_vld_i (layer_vld),
		.layer_px_i  (layer_px),
		.layer_rdy_o (layer_rdy),
		.pram_wr_i   (pram_wr),
		.pix_vld_o   (pix_vld),
		.pix_o       (pix),
		.pix_rdy_i   (pix_rdy),
		.beam_o      (beam),
		.running_o   (running)
	);

	initial begin
		clk_ppu = 1'b0;
		forever #50 clk_ppu = ~clk_ppu;
	end

	// --------------------------------------------------
	// Table contents
	// --------------------------------------------------

	task automatic add_test(input int i, input logic [3:0] opq, input logic [3:0] pal,
		input logic [14:0] w3, w2, w1, w0, input logic [14:0] exp);
		t_opq[i]     = opq;
		t_pal[i]     = pal;
		t_word[i][3] = w3;
		t_word[i][2] = w2;
		t_word[i][1] = w1;
		t_word[i][0] = w0;
		t_exp[i]     = exp;
	endtask

	task automatic fill_tables();
		p_addr[0] = 8'h03;
		p_data[0] = 15'h1a2b;
		p_addr[1] = 8'h7f;
		p_data[1] = 15'h7c00;
		p_addr[2] = 8'hc5;
		p_data[2] = 15'h03e0;
		p_addr[3] = 8'hff;
		p_data[3] = 15'h001f;
		// Default colour is 15'h2108
		add_test(0,  4'b0000, 4'b0000, 15'h1111, 15'h2222, 15'h3333, 15'h4444, 15'h2108);
		add_test(1,  4'b0001, 4'b0000, 15'h1111, 15'h2222, 15'h3333, 15'h0421, 15'h0421);
		add_test(2,  4'b1011, 4'b0000, 15'h7fff, 15'h2222, 15'h1111, 15'h0001, 15'h7fff);
		add_test(3,  4'b0110, 4'b0100, 15'h6666, 15'h0003, 15'h5555, 15'h0002, 15'h1a2b);
		add_test(4,  4'b0111, 4'b0010, 15'h0ff0, 15'h00c5, 15'h00ff, 15'h0003, 15'h00c5);
		// Pad bits above the index are ignored
		add_test(5,  4'b1000, 4'b1000, 15'h7f7f, 15'h0003, 15'h00ff, 15'h00c5, 15'h7c00);
		add_test(6,  4'b0011, 4'b0001, 15'h1234, 15'h4321, 15'h4210, 15'h0003, 15'h4210);
		add_test(7,  4'b1111, 4'b1111, 15'h00ff, 15'h0003, 15'h007f, 15'h00c5, 15'h001f);
		add_test(8,  4'b0000, 4'b1111, 15'h00ff, 15'h0003, 15'h007f, 15'h00c5, 15'h2108);
		add_test(9,  4'b0100, 4'b0100, 15'h0003, 15'h00c5, 15'h00ff, 15'h0101, 15'h03e0);
		add_test(10, 4'b0010, 4'b0010, 15'h0c5c, 15'h00ff, 15'h0003, 15'h7f7f, 15'h1a2b);
		add_test(11, 4'b1001, 4'b0001, 15'h3def, 15'h00c5, 15'h0003, 15'h00ff, 15'h3def);
	endtask

	// --------------------------------------------------
	// Stimulus and checks
	// --------------------------------------------------

	task automatic apply_reset();
		rst_n_ppu = 1'b0;
		n_acc     = 0;
		repeat (8) @(posedge clk_ppu);
		#10;
		rst_n_ppu = 1'b1;
	endtask

	task automatic set_layers(input int i);
		for (int l = 0; l < `PPU_N_LAYERS; l++) begin
			layer_px[l].opaque   = t_opq[i][l];
			layer_px[l].paletted = t_pal[i][l];
			layer_px[l].word     = t_word[i][l];
		end
		layer_vld = '1;
	endtask

	task automatic record(input int i);
		sb_id.push_back(i);
		sb_exp.push_back(t_exp[i]);
		n_acc++;
	endtask

	// Hold the pixel until the layer transfer
	task automatic send_pixel(input int i);
		logic taken;
		taken = 1'b0;
		set_layers(i);
		while (!taken) begin
			@(negedge clk_ppu);
			if (layer_rdy === 1'b1) begin
				taken = 1'b1;
				record(i);
			end
			@(posedge clk_ppu);
			#10;
		end
		layer_vld = '0;
	endtask

	task automatic check_beam();
		assert (int'(beam.x) == n_acc % DISP_W && int'(beam.y) == (n_acc / DISP_W) % DISP_H)
			n_pass++;
		else begin
			$display("CHECK FAILED at %0t: beam (%0d,%0d) after %0d pixels",
				$time, beam.x, beam.y, n_acc);
			n_fail++;
		end
	endtask

	// Layers stay valid while the pipe must refuse them
	task automatic check_stopped(input int n);
		set_layers(0);
		repeat (n) begin
			@(negedge clk_ppu);
			assert (running === 1'b0 && layer_rdy === 1'b0) n_pass++;
			else begin
				$display("CHECK FAILED at %0t: pipe still running after halt", $time);
				n_fail++;
			end
			@(posedge clk_ppu);
			#10;
		end
		layer_vld = '0;
	endtask

	task automatic wait_drain();
		while (sb_exp.size() != 0) @(posedge clk_ppu);
		#10;
	endtask

	task automatic run_row(input int row);
		int start_acc;
		int start_out;
		int start_fail;
		int i;
		start_acc  = n_acc;
		start_out  = n_out;
		start_fail = n_fail;
		i          = 0;
		run = 1'b1;
		@(posedge clk_ppu);
		#10;
		run = 1'b0;
		while (n_acc - start_acc < DISP_W) begin
			send_pixel(i % N_TESTS);
			check_beam();
			i++;
		end
		check_stopped(4);
		wait_drain();
		assert (n_out - start_out == DISP_W) n_pass++;
		else begin
			$display("CHECK FAILED at %0t: row %0d gave %0d pixels", $time, row, n_out - start_out);
			n_fail++;
		end
		$display("row halt test %0d: %0d pixels, %0d failures",
			row, n_out - start_out, n_fail - start_fail);
	endtask

	// Output side, sampled mid-cycle where everything is settled
	always @(negedge clk_ppu) begin
		int                        id;
		logic [`PPU_W_PIXDATA-1:0] exp;
		if (rst_n_ppu && pix_vld === 1'b1 && pix_rdy) begin
			n_out++;
			if (sb_exp.size() == 0) begin
				$display("Pixel %h came out at %0t while none was expected", pix, $time);
				n_fail++;
			end else begin
				id  = sb_id.pop_front();
				exp = sb_exp.pop_front();
				assert (pix == exp) begin
					n_pass++;
					$display("test %0d: pixel %h ok", id, pix);
				end else begin
					$display("CHECK FAILED at %0t: test %0d pixel %h, expected %h",
						$time, id, pix, exp);
					n_fail++;
				end
			end
		end
	end

	// Random back-pressure, ready about three cycles out of four
	always @(posedge clk_ppu) begin
		#10;
		pix_rdy = ($random(seed) & 3) != 0;
	end

	always @(posedge clk_ppu) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		int start_fail;
		seed      = 32'hcb45_1f40;
		rst_n_ppu = 1'b0;
		run       = 1'b0;
		halt      = 1'b0;
		layer_vld = '0;
		layer_px  = '0;
		pram_wr   = '0;
		pix_rdy   = 1'b0;
		cfg       = '0;
		cfg.default_colour = 15'h2108;
		cfg.disp_w = 9'(DISP_W);
		cfg.disp_h = 9'(DISP_H);
		n_pass = 0;
		n_fail = 0;
		n_out  = 0;
		cycles = 0;
		fill_tables();
		apply_reset();

		for (int p = 0; p < N_PAL; p++) begin
			pram_wr.en   = 1'b1;
			pram_wr.addr = p_addr[p];
			pram_wr.data = p_data[p];
			@(posedge clk_ppu);
			#10;
		end
		pram_wr.en = 1'b0;

		// Priority, palette, back-pressure and beam
		run = 1'b1;
		@(posedge clk_ppu);
		#10;
		run = 1'b0;
		for (int i = 0; i < N_TESTS; i++) begin
			send_pixel(i);
			check_beam();
		end
		wait_drain();

		// Halt strobe, a pixel taken in the same cycle still drains
		start_fail = n_fail;
		halt = 1'b1;
		set_layers(1);
		@(negedge clk_ppu);
		if (layer_rdy === 1'b1) begin
			record(1);
		end
		@(posedge clk_ppu);
		#10;
		halt = 1'b0;
		check_stopped(3);
		wait_drain();
		$display("halt strobe test: %0d failures", n_fail - start_fail);

		// Halt at row start, twice from a fresh beam
		apply_reset();
		cfg.halt_hsync = 1'b1;
		run_row(0);
		run_row(1);

		$display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* sim/ppu_backend_chk.sv */
module ppu_backend_chk (
	input logic              clk_ppu,
	input logic              rst_n_ppu,
	input logic              pix_vld_o,
	input logic              pix_rdy_i,
	input ppu_pkg::ppu_rgb_t pix_o,
	input logic              layer_rdy_o,
	input logic              running_o
);

	// Output register is empty while reset is held
	a_vld_reset: assert property (@(posedge clk_ppu) !rst_n_ppu |-> !pix_vld_o)
		else $error("pix_vld_o high during reset");

	// A stalled pixel keeps its value until taken
	a_out_hold: assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu)
		pix_vld_o && !pix_rdy_i |=> pix_vld_o && $stable(pix_o))
		else $error("output pixel changed while stalled");

	// Layers are only taken while the pipe runs
	a_rdy_run: assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu)
		!running_o |-> !layer_rdy_o)
		else $error("layer_rdy_o high while not running");

endmodule

bind ppu_backend ppu_backend_chk u_chk (
	.clk_ppu     (clk_ppu),
	.rst_n_ppu   (rst_n_ppu),
	.pix_vld_o   (pix_vld_o),
	.pix_rdy_i   (pix_rdy_i),
	.pix_o       (pix_o),
	.layer_rdy_o (layer_rdy_o),
	.running_o   (running_o)
);

/* src/ppu_backend.sv */
`include "ppu_settings.svh"

module ppu_backend (
	input  logic                                       clk_ppu,
	input  logic                                       rst_n_ppu,
	input  ppu_pkg::ppu_cfg_t                          cfg_i,
	input  logic                                       run_i,
	input  logic                                       halt_i,
	input  logic [`PPU_N_LAYERS-1:0]                   layer_vld_i,
	input  ppu_pkg::ppu_layer_px_t [`PPU_N_LAYERS-1:0] layer_px_i,
	output logic                                       layer_rdy_o,
	input  ppu_pkg::ppu_pram_wr_t                      pram_wr_i,
	output logic                                       pix_vld_o,
	output ppu_pkg::ppu_rgb_t                          pix_o,
	input  logic                                       pix_rdy_i,
	output ppu_pkg::ppu_beam_t                         beam_o,
	output logic                                       running_o
);

	logic                   blend_vld;
	ppu_pkg::ppu_blend_px_t blend_px;
	logic                   pmap_rdy;

	// --------------------------------------------------
	// Raster counter and run control
	// --------------------------------------------------

	// Beam steps once per pixel handed to the mapper
	ppu_raster_ctrl u_raster_ctrl (
		.clk_ppu   (clk_ppu),
		.rst_n_ppu (rst_n_ppu),
		.cfg_i     (cfg_i),
		.run_i     (run_i),
		.halt_i    (halt_i),
		.advance_i (blend_vld && pmap_rdy && running_o),
		.beam_o    (beam_o),
		.running_o (running_o)
	);

	// --------------------------------------------------
	// Blender and palette lookup
	// --------------------------------------------------

	// Blend handshake only counts while running
	ppu_blender u_blender (
		.layer_vld_i      (layer_vld_i),
		.layer_px_i       (layer_px_i),
		.layer_rdy_o      (layer_rdy_o),
		.default_colour_i (cfg_i.default_colour),
		.out_vld_o        (blend_vld),
		.out_px_o         (blend_px),
		.out_rdy_i        (pmap_rdy && running_o)
	);

	ppu_palette_mapper u_palette_mapper (
		.clk_ppu   (clk_ppu),
		.rst_n_ppu (rst_n_ppu),
		.in_vld_i  (blend_vld && running_o),
		.in_px_i   (blend_px),
		.in_rdy_o  (pmap_rdy),
		.pram_wr_i (pram_wr_i),
		.pix_vld_o (pix_vld_o),
		.pix_o     (pix_o),
		.pix_rdy_i (pix_rdy_i)
	);

endmodule

/* src/ppu_palette_mapper.sv */
`include "ppu_settings.svh"

module ppu_palette_mapper (
	input  logic                   clk_ppu,
	input  logic                   rst_n_ppu,
	input  logic                   in_vld_i,
	input  ppu_pkg::ppu_blend_px_t in_px_i,
	output logic                   in_rdy_o,
	input  ppu_pkg::ppu_pram_wr_t  pram_wr_i,
	output logic                   pix_vld_o,
	output ppu_pkg::ppu_rgb_t      pix_o,
	input  logic                   pix_rdy_i
);

	ppu_pkg::ppu_rgb_t pram [`PPU_PAL_DEPTH];
	ppu_pkg::ppu_rgb_t lookup;
	logic              load;

	// --------------------------------------------------
	// Palette RAM
	// --------------------------------------------------

	always_ff @(posedge clk_ppu) begin
		if (pram_wr_i.en) begin
			pram[pram_wr_i.addr] <= pram_wr_i.data;
		end
	end

	// Asynchronous read, index or direct colour from the same word
	assign lookup = in_px_i.paletted ? pram[in_px_i.word.pal.idx] : in_px_i.word.rgb;

	// --------------------------------------------------
	// Output register
	// --------------------------------------------------

	// Take a new pixel when empty or when the current one leaves
	assign in_rdy_o = !pix_vld_o || pix_rdy_i;
	assign load     = in_vld_i && in_rdy_o;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			pix_vld_o <= 1'b0;
		end else if (load) begin
			pix_vld_o <= 1'b1;
		end else if (pix_rdy_i) begin
			pix_vld_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_ppu) begin
		if (load) begin
			pix_o <= lookup;
		end
	end

endmodule

/* src/ppu_blender.sv */
`include "ppu_settings.svh"

module ppu_blender (
	input  logic [`PPU_N_LAYERS-1:0]                   layer_vld_i,
	input  ppu_pkg::ppu_layer_px_t [`PPU_N_LAYERS-1:0] layer_px_i,
	output logic                                       layer_rdy_o,
	input  ppu_pkg::ppu_rgb_t                          default_colour_i,
	output logic                                       out_vld_o,
	output ppu_pkg::ppu_blend_px_t                     out_px_o,
	input  logic                                       out_rdy_i
);

	// --------------------------------------------------
	// Stream handshake
	// --------------------------------------------------

	// All layers move together, one pixel each
	assign out_vld_o   = &layer_vld_i;
	assign layer_rdy_o = out_rdy_i;

	// --------------------------------------------------
	// Priority select
	// --------------------------------------------------

	// Highest opaque index wins
	always_comb begin
		out_px_o.paletted = 1'b0;
		out_px_o.word.rgb = default_colour_i;
		for (int l = 0; l < `PPU_N_LAYERS; l++) begin
			if (layer_px_i[l].opaque) begin
				out_px_o.paletted = layer_px_i[l].paletted;
				out_px_o.word     = layer_px_i[l].word;
			end
		end
	end

endmodule

/* src/ppu_raster_ctrl.sv */
`include "ppu_settings.svh"

module ppu_raster_ctrl (
	input  logic               clk_ppu,
	input  logic               rst_n_ppu,
	input  ppu_pkg::ppu_cfg_t  cfg_i,
	input  logic               run_i,
	input  logic               halt_i,
	input  logic               advance_i,
	output ppu_pkg::ppu_beam_t beam_o,
	output logic               running_o
);

	logic [`PPU_W_COORD-1:0] x_last;
	logic [`PPU_W_COORD-1:0] y_last;
	logic                    x_wrap;
	logic                    y_wrap;
	ppu_pkg::ppu_beam_t      beam_q;
	logic                    hsync_q;
	logic                    vsync_q;
	logic                    running_q;

	// --------------------------------------------------
	// Beam counter
	// --------------------------------------------------

	assign x_last = cfg_i.disp_w - 1'b1;
	assign y_last = cfg_i.disp_h - 1'b1;
	assign x_wrap = beam_q.x == x_last;
	assign y_wrap = beam_q.y == y_last;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			beam_q  <= '0;
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
		end else begin
			// Pulses mark the first cycle at a new row or frame
			hsync_q <= advance_i && x_wrap;
			vsync_q <= advance_i && x_wrap && y_wrap;
			if (advance_i) begin
				if (x_wrap) begin
					beam_q.x <= '0;
					beam_q.y <= y_wrap ? '0 : beam_q.y + 1'b1;
				end else begin
					beam_q.x <= beam_q.x + 1'b1;
				end
			end
		end
	end

	assign beam_o = beam_q;

	// --------------------------------------------------
	// Run control
	// --------------------------------------------------

	// Enabled sync pulse masks the run state in the same cycle
	assign running_o = running_q &&
		!((cfg_i.halt_hsync && hsync_q) || (cfg_i.halt_vsync && vsync_q));

	// Halt strobe beats run strobe
	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			running_q <= 1'b0;
		end else begin
			running_q <= (running_o || run_i) && !halt_i;
		end
	end

endmodule

/* src/ppu_pkg.sv */
`include "ppu_settings.svh"

package ppu_pkg;

	// --------------------------------------------------
	// Pixel words
	// --------------------------------------------------

	typedef struct packed {
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
	} ppu_rgb_t;

	// Index sits in the low bits of the word
	typedef struct packed {
		logic [`PPU_W_PIXDATA-`PPU_W_PAL_IDX-1:0] pad;
		logic [`PPU_W_PAL_IDX-1:0]                idx;
	} ppu_palidx_t;

	// Same word read as direct colour or as palette index
	typedef union packed {
		ppu_rgb_t    rgb;
		ppu_palidx_t pal;
	} ppu_pixword_u;

	typedef struct packed {
		logic         opaque;
		logic         paletted;
		ppu_pixword_u word;
	} ppu_layer_px_t;

	typedef struct packed {
		logic         paletted;
		ppu_pixword_u word;
	} ppu_blend_px_t;

	// --------------------------------------------------
	// Beam, configuration and palette writes
	// --------------------------------------------------

	typedef struct packed {
		logic [`PPU_W_COORD-1:0] x;
		logic [`PPU_W_COORD-1:0] y;
	} ppu_beam_t;

	// Display sizes hold last coordinate plus one
	typedef struct packed {
		ppu_rgb_t                default_colour;
		logic [`PPU_W_COORD-1:0] disp_w;
		logic [`PPU_W_COORD-1:0] disp_h;
		logic                    halt_hsync;
		logic                    halt_vsync;
	} ppu_cfg_t;

	typedef struct packed {
		logic                      en;
		logic [`PPU_W_PAL_IDX-1:0] addr;
		logic [`PPU_W_PIXDATA-1:0] data;
	} ppu_pram_wr_t;

endpackage

/* src/ppu_settings.svh */
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// --------------------------------------------------
// Pixel pipe dimensions
// --------------------------------------------------

// Layer streams into the blender, highest index wins
`define PPU_N_LAYERS 4

// RGB555 pixel word
`define PPU_W_PIXDATA 15

// Screen coordinate width
`define PPU_W_COORD 9

// Palette index width and number of entries
`define PPU_W_PAL_IDX 8
`define PPU_PAL_DEPTH 256

`endif
